/* src/reel_display_pkg.sv */
package reel_display_pkg;

    //////////////////////////////////////////////////////////////
    // Sprite geometry and screen layout
    //////////////////////////////////////////////////////////////
    localparam int num_sprites  = 7;
    localparam int sprite_size  = 64;
    localparam int pixel_scale  = 2;
    localparam int strip_height = num_sprites * sprite_size * pixel_scale;
    localparam int reel_width   = sprite_size * pixel_scale;

    localparam int reel_start_h [3] = '{190, 398, 606};
    localparam int reels_start_v      = 60;
    localparam int reel_window_height = 430;

    // Puts the middle of a sprite on the middle of the window
    localparam int centering_offset = reel_window_height / 2 - reel_width / 2;

    typedef logic [9:0]  offset_t;
    typedef logic [2:0]  sprite_idx_t;
    // Sprite index on top, then row and word column
    typedef logic [12:0] rom_addr_t;

    // Order of the sprites on each reel strip, top to bottom
    localparam sprite_idx_t reel_strip [3][num_sprites] = '{
        '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6},
        '{3'd3, 3'd0, 3'd6, 3'd1, 3'd4, 3'd2, 3'd5},
        '{3'd2, 3'd5, 3'd1, 3'd6, 3'd3, 3'd0, 3'd4}
    };

    // Four pixels per ROM word, leftmost pixel in the top nibble
    typedef union packed {
        logic [15:0]      raw;
        logic [0:3][3:0]  slot;
    } sprite_word_t;

    // Pattern rule the sprite ROM is built from
    function automatic logic [2:0] sprite_color(
        input int unsigned s,
        input int unsigned y,
        input int unsigned x
    );
        return 3'(s + y + x);
    endfunction

endpackage

/* src/reel_spin_pkg.sv */
package reel_spin_pkg;

    typedef enum logic [2:0] {
        idle,
        spin_all,
        stop_reel1,
        stop_reel2,
        stop_reel3,
        finished
    } spin_state_t;

    //////////////////////////////////////////////////////////////
    // Reel motion per frame
    //////////////////////////////////////////////////////////////
    localparam int fast_step = 24;
    localparam int slow_step = 12;

    // Full turns each reel makes before it may stop
    localparam logic [1:0] spin_turns [3] = '{2'd3, 2'd2, 2'd2};

    //////////////////////////////////////////////////////////////
    // State LED codes
    //////////////////////////////////////////////////////////////
    localparam logic [2:0] led_idle       = 3'b000;
    localparam logic [2:0] led_spin_all   = 3'b100;
    localparam logic [2:0] led_stop_reel1 = 3'b101;
    localparam logic [2:0] led_stop_reel2 = 3'b001;
    localparam logic [2:0] led_stop_reel3 = 3'b110;
    localparam logic [2:0] led_finished   = 3'b111;

endpackage

/* src/reel_spin_ctrl.sv */
`timescale 1ns/10ps

module reel_spin_ctrl
    import reel_display_pkg::*;
    import reel_spin_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        vsync,
    input  logic        start_spin,
    input  sprite_idx_t final1_sprite,
    input  sprite_idx_t final2_sprite,
    input  sprite_idx_t final3_sprite,
    output offset_t     reel_offset [3],
    output logic        done,
    output logic [2:0]  state_led
);

    logic        vsync_q;
    logic        frame_tick;
    logic        spin_req;
    spin_state_t state;
    spin_state_t next_state;
    logic [1:0]  turns [3];
    logic [1:0]  next_turns [3];
    offset_t     next_offset [3];
    sprite_idx_t final_sprite [3];
    offset_t     end_offset [3];

    function automatic logic [2:0] led_for(input spin_state_t s);
        case (s)
            spin_all:   return led_spin_all;
            stop_reel1: return led_stop_reel1;
            stop_reel2: return led_stop_reel2;
            stop_reel3: return led_stop_reel3;
            finished:   return led_finished;
            default:    return led_idle;
        endcase
    endfunction

    // Strip line that centres sprite s of reel r in the window
    function automatic offset_t ending_for(input int r, input sprite_idx_t s);
        logic [10:0] lines;
        lines = '0;
        for (int p = 0; p < num_sprites; p++) begin
            if (reel_strip[r][p] == s) begin
                lines = 11'(p * reel_width);
            end
        end
        lines = lines + 11'(strip_height - centering_offset);
        if (lines >= 11'(strip_height)) begin
            lines = lines - 11'(strip_height);
        end
        return offset_t'(lines);
    endfunction

    ////////////////////////////////////////////////////////////
    // Frame tick on the falling edge of vsync
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            vsync_q    <= 1'b0;
            frame_tick <= 1'b0;
        end else begin
            vsync_q    <= vsync;
            frame_tick <= vsync_q && !vsync;
        end
    end

    // Final sprites only follow the inputs before the spin
    always_ff @(posedge clk) begin
        if (state == idle && start_spin) begin
            final_sprite[0] <= final1_sprite;
            final_sprite[1] <= final2_sprite;
            final_sprite[2] <= final3_sprite;
        end
    end

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            end_offset[r] = ending_for(r, final_sprite[r]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Next offsets and state
    ////////////////////////////////////////////////////////////
    always_comb begin
        int          stage;
        logic [10:0] sum;
        logic [10:0] gap;
        // Reels below the stage creep to a stop while the others spin
        stage      = int'(state) - 1;
        next_state = state;
        sum        = '0;
        gap        = '0;
        for (int r = 0; r < 3; r++) begin
            next_offset[r] = reel_offset[r];
            next_turns[r]  = turns[r];
            if (state != idle && stage <= r) begin
                sum = 11'(reel_offset[r]) + 11'(fast_step);
                if (sum >= 11'(strip_height)) begin
                    next_offset[r] = offset_t'(sum - 11'(strip_height));
                    if (turns[r] != 2'd0) begin
                        next_turns[r] = turns[r] - 2'd1;
                    end else if (stage == r) begin
                        next_state = spin_state_t'(state + 3'd1);
                    end
                end else begin
                    next_offset[r] = offset_t'(sum);
                end
            end else if (state != idle) begin
                if (end_offset[r] >= reel_offset[r]) begin
                    gap = 11'(end_offset[r]) - 11'(reel_offset[r]);
                end else begin
                    gap = 11'(end_offset[r]) + 11'(strip_height) - 11'(reel_offset[r]);
                end
                if (gap <= 11'(slow_step)) begin
                    next_offset[r] = end_offset[r];
                end else begin
                    sum = 11'(reel_offset[r]) + 11'(slow_step);
                    if (sum >= 11'(strip_height)) begin
                        sum = sum - 11'(strip_height);
                    end
                    next_offset[r] = offset_t'(sum);
                end
            end
        end
        if (state == idle && spin_req) begin
            next_state = spin_all;
            for (int r = 0; r < 3; r++) begin
                next_turns[r] = spin_turns[r];
            end
        end
        if (state == stop_reel3 && reel_offset[2] == end_offset[2]) begin
            next_state = finished;
        end
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state     <= idle;
            spin_req  <= 1'b0;
            state_led <= led_idle;
            for (int r = 0; r < 3; r++) begin
                reel_offset[r] <= '0;
                turns[r]       <= '0;
            end
        end else begin
            if (state == idle && start_spin) begin
                spin_req <= 1'b1;
            end else if (state != idle) begin
                spin_req <= 1'b0;
            end
            if (frame_tick) begin
                state     <= next_state;
                state_led <= led_for(next_state);
                for (int r = 0; r < 3; r++) begin
                    reel_offset[r] <= next_offset[r];
                    turns[r]       <= next_turns[r];
                end
            end
        end
    end

    assign done = (state == finished);

    for (genvar r = 0; r < 3; r++) begin : g_offset_range
        assert property (@(posedge clk) disable iff (!reset_n)
            reel_offset[r] < strip_height);
    end

    // The FSM only ever moves one stage forward
    assert property (@(posedge clk) disable iff (!reset_n)
        state != $past(state) |-> state == spin_state_t'($past(state) + 3'd1));

endmodule

/* src/reel_scan_addr.sv */
`timescale 1ns/10ps

module reel_scan_addr
    import reel_display_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [10:0] hcount,
    input  logic [9:0]  vcount,
    input  logic        active_video,
    input  offset_t     reel_offset [3],
    output rom_addr_t   rom_addr,
    output logic [1:0]  pixel_slot,
    output logic        inside_reel,
    output logic        active
);

    logic        in_window_v;
    logic        hit;
    logic [1:0]  reel_sel;
    logic [10:0] line_sum;
    offset_t     reel_line;
    logic [10:0] col_full;
    logic [5:0]  row;
    logic [5:0]  col;
    sprite_idx_t sprite;

    ////////////////////////////////////////////////////////////
    // Which reel window holds the beam
    ////////////////////////////////////////////////////////////
    assign in_window_v = (vcount >= reels_start_v) &&
                         (vcount < reels_start_v + reel_window_height);

    always_comb begin
        hit      = 1'b0;
        reel_sel = 2'd0;
        for (int r = 2; r >= 0; r--) begin
            if (in_window_v && hcount >= reel_start_h[r] &&
                hcount < reel_start_h[r] + reel_width) begin
                hit      = 1'b1;
                reel_sel = 2'(r);
            end
        end
    end

    // Strip line, then sprite, row and column within it
    always_comb begin
        line_sum  = '0;
        reel_line = '0;
        col_full  = '0;
        sprite    = '0;
        if (hit) begin
            line_sum = 11'(vcount) - 11'(reels_start_v) + 11'(reel_offset[reel_sel]);
            if (line_sum >= 11'(strip_height)) begin
                line_sum = line_sum - 11'(strip_height);
            end
            reel_line = offset_t'(line_sum);
            sprite    = reel_strip[reel_sel][reel_line[9:7]];
            col_full  = hcount - 11'(reel_start_h[reel_sel]);
        end
        row = 6'(reel_line[6:0] / pixel_scale);
        col = 6'(col_full / pixel_scale);
    end

    always_ff @(posedge clk) begin
        rom_addr   <= {sprite, row, col[5:2]};
        pixel_slot <= col[1:0];
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            inside_reel <= 1'b0;
            active      <= 1'b0;
        end else begin
            inside_reel <= hit;
            active      <= active_video;
        end
    end

    // Every reel hit addresses a sprite that exists in the ROM
    assert property (@(posedge clk) disable iff (!reset_n)
        inside_reel |-> rom_addr[12:10] < num_sprites);

endmodule

/* src/sprite_rom.sv */
`timescale 1ns/10ps

module sprite_rom
    import reel_display_pkg::*;
(
    input  logic         clk,
    input  rom_addr_t    rom_addr,
    output sprite_word_t rom_word
);

    sprite_word_t mem [num_sprites * 1024];

    // Fill from the pattern rule, four pixels per word
    initial begin
        logic [15:0] packed_px;
        packed_px = '0;
        for (int s = 0; s < num_sprites; s++) begin
            for (int y = 0; y < sprite_size; y++) begin
                for (int w = 0; w < sprite_size / 4; w++) begin
                    for (int k = 0; k < 4; k++) begin
                        packed_px[15 - 4 * k -: 3] = sprite_color(s, y, 4 * w + k);
                        packed_px[12 - 4 * k]      = 1'b0;
                    end
                    mem[rom_addr_t'({3'(s), 6'(y), 4'(w)})].raw = packed_px;
                end
            end
        end
    end

    // One clock read latency
    always_ff @(posedge clk) begin
        rom_word <= mem[rom_addr];
    end

endmodule

/* src/pixel_out.sv */
`timescale 1ns/10ps

module pixel_out
    import reel_display_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  sprite_word_t rom_word,
    input  logic [1:0]   pixel_slot,
    input  logic         inside_reel,
    input  logic         active,
    output logic [2:0]   pixel_rgb
);

    logic [1:0] slot_q;
    logic       inside_q;
    logic       active_q;
    logic [2:0] color;

    // Line up slot and flags with the ROM data
    always_ff @(posedge clk) begin
        slot_q <= pixel_slot;
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            inside_q <= 1'b0;
            active_q <= 1'b0;
        end else begin
            inside_q <= inside_reel;
            active_q <= active;
        end
    end

    // Colour sits above the pad bit in each nibble
    assign color = rom_word.slot[slot_q][3:1];

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            pixel_rgb <= 3'b000;
        end else begin
            pixel_rgb <= (inside_q && active_q) ? color : 3'b000;
        end
    end

    // Shown pixels come from a nibble with a clear pad bit
    assert property (@(posedge clk) disable iff (!reset_n)
        inside_q && active_q |-> rom_word.slot[slot_q][0] == 1'b0);

endmodule

/* src/slot_reels_top.sv */
`timescale 1ns/10ps

module slot_reels_top
    import reel_display_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [10:0] hcount,
    input  logic [9:0]  vcount,
    input  logic        vsync,
    input  logic        active_video,
    input  logic        start_spin,
    input  sprite_idx_t final1_sprite,
    input  sprite_idx_t final2_sprite,
    input  sprite_idx_t final3_sprite,
    output logic [2:0]  pixel_rgb,
    output logic        done,
    output logic [2:0]  state_led
);

    offset_t      reel_offset [3];
    rom_addr_t    rom_addr;
    logic [1:0]   pixel_slot;
    logic         inside_reel;
    logic         active;
    sprite_word_t rom_word;

    reel_spin_ctrl i_spin_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .vsync         (vsync),
        .start_spin    (start_spin),
        .final1_sprite (final1_sprite),
        .final2_sprite (final2_sprite),
        .final3_sprite (final3_sprite),
        .reel_offset   (reel_offset),
        .done          (done),
        .state_led     (state_led)
    );

    // Pixel pipeline of scan, ROM read and output stages
    reel_scan_addr i_scan_addr (
        .clk          (clk),
        .reset_n      (reset_n),
        .hcount       (hcount),
        .vcount       (vcount),
        .active_video (active_video),
        .reel_offset  (reel_offset),
        .rom_addr     (rom_addr),
        .pixel_slot   (pixel_slot),
        .inside_reel  (inside_reel),
        .active       (active)
    );

    sprite_rom i_sprite_rom (
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_word (rom_word)
    );

    pixel_out i_pixel_out (
        .clk         (clk),
        .reset_n     (reset_n),
        .rom_word    (rom_word),
        .pixel_slot  (pixel_slot),
        .inside_reel (inside_reel),
        .active      (active),
        .pixel_rgb   (pixel_rgb)
    );

endmodule

/* tests/tb_slot_reels.sv */
`timescale 1ns/10ps

module tb_slot_reels
    import reel_display_pkg::*;
    import reel_spin_pkg::*;
();

    localparam int max_spin_frames = 400;
    localparam int settle_frames   = 80;
    localparam int frame_cycles    = 24;
    localparam int cycle_limit     = (max_spin_frames + settle_frames + 8) * frame_cycles + 1000;

    logic        clk = 1'b0;
    logic        reset_n;
    logic [10:0] hcount;
    logic [9:0]  vcount;
    logic        vsync;
    logic        active_video;
    logic        start_spin;
    sprite_idx_t final1_sprite;
    sprite_idx_t final2_sprite;
    sprite_idx_t final3_sprite;
    logic [2:0]  pixel_rgb;
    logic        done;
    logic [2:0]  state_led;

    logic [31:0] lcg = 32'hc7f5;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    // Reference copy of the spin, advanced once per emitted frame
    int m_state;
    int m_req;
    int m_off [3];
    int m_turns [3];
    int m_end [3];
    int latched [3];

    slot_reels_top i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .hcount        (hcount),
        .vcount        (vcount),
        .vsync         (vsync),
        .active_video  (active_video),
        .start_spin    (start_spin),
        .final1_sprite (final1_sprite),
        .final2_sprite (final2_sprite),
        .final3_sprite (final3_sprite),
        .pixel_rgb     (pixel_rgb),
        .done          (done),
        .state_led     (state_led)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the spin never settled", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return (lcg >> 8) % n;
    endfunction

    // Any sprite index other than s
    function automatic sprite_idx_t other_sprite(input int s);
        return 3'((s + 1 + int'(rand_below(num_sprites - 1))) % num_sprites);
    endfunction

    function automatic logic [2:0] model_color(input int s, input int y, input int x);
        return 3'((s + y + x) % 8);
    endfunction

    function automatic logic [2:0] led_of(input int st);
        case (st)
            int'(spin_all):   return led_spin_all;
            int'(stop_reel1): return led_stop_reel1;
            int'(stop_reel2): return led_stop_reel2;
            int'(stop_reel3): return led_stop_reel3;
            int'(finished):   return led_finished;
            default:          return led_idle;
        endcase
    endfunction

    // Strip line that centres the final sprite in the window
    function automatic int ending_line(input int r, input int s);
        int pos;
        pos = 0;
        for (int p = 0; p < num_sprites; p++) begin
            if (int'(reel_strip[r][p]) == s) begin
                pos = p;
            end
        end
        return (pos * reel_width + strip_height - centering_offset) % strip_height;
    endfunction

    function automatic logic [2:0] expect_pixel(input int h, input int v, input logic av);
        int line;
        if (!av || v < reels_start_v || v >= reels_start_v + reel_window_height) begin
            return 3'd0;
        end
        for (int r = 0; r < 3; r++) begin
            if (h >= reel_start_h[r] && h < reel_start_h[r] + reel_width) begin
                line = (v - reels_start_v + m_off[r]) % strip_height;
                return model_color(int'(reel_strip[r][line / reel_width]),
                                   (line % reel_width) / 2, (h - reel_start_h[r]) / 2);
            end
        end
        return 3'd0;
    endfunction

    //////////////////////////////////////////////////////////////
    // Motion rules, one frame tick
    //////////////////////////////////////////////////////////////
    function automatic void advance_model();
        int nxt;
        int gap;
        nxt = m_state;
        if (m_state == int'(idle)) begin
            if (m_req != 0) begin
                nxt   = int'(spin_all);
                m_req = 0;
                for (int r = 0; r < 3; r++) begin
                    m_turns[r] = int'(spin_turns[r]);
                end
            end
        end else begin
            if (m_state == int'(stop_reel3) && m_off[2] == m_end[2]) begin
                nxt = int'(finished);
            end
            for (int r = 0; r < 3; r++) begin
                // Reel r keeps spinning until stop_reel(r+1)
                if (m_state <= int'(spin_all) + r) begin
                    m_off[r] = m_off[r] + fast_step;
                    if (m_off[r] >= strip_height) begin
                        m_off[r] = m_off[r] - strip_height;
                        if (m_turns[r] > 0) begin
                            m_turns[r] = m_turns[r] - 1;
                        end else if (m_state == int'(spin_all) + r) begin
                            nxt = m_state + 1;
                        end
                    end
                end else begin
                    gap = (m_end[r] - m_off[r] + strip_height) % strip_height;
                    if (gap <= slow_step) begin
                        m_off[r] = m_end[r];
                    end else begin
                        m_off[r] = (m_off[r] + slow_step) % strip_height;
                    end
                end
            end
        end
        m_state = nxt;
    endfunction

    task automatic check_state();
        checks = checks + 2;
        assert (state_led == led_of(m_state)) else begin
            errors++;
            $display("[FAIL] state_led expected %h got %h", led_of(m_state), state_led);
        end
        assert (done == (m_state == int'(finished))) else begin
            errors++;
            $display("[FAIL] done expected %h got %h", m_state == int'(finished), done);
        end
    endtask

    // Output register holds the result three clocks after the position
    task automatic check_pixel(input int h, input int v, input logic av, input logic [2:0] exp);
        hcount       = 11'(h);
        vcount       = 10'(v);
        active_video = av;
        repeat (3) @(negedge clk);
        checks++;
        assert (pixel_rgb == exp) else begin
            errors++;
            $display("[FAIL] pixel_rgb expected %h got %h (h=%0d v=%0d)", exp, pixel_rgb, h, v);
        end
    endtask

    task automatic emit_frame();
        vsync = 1'b1;
        @(negedge clk);
        vsync = 1'b0;
        repeat (3) @(negedge clk);
        advance_model();
        check_state();
    endtask

    task automatic sample_frame_pixels();
        int   h;
        int   v;
        logic av;
        for (int r = 0; r < 3; r++) begin
            h = reel_start_h[r] + int'(rand_below(reel_width));
            v = reels_start_v + int'(rand_below(reel_window_height));
            check_pixel(h, v, 1'b1, expect_pixel(h, v, 1'b1));
        end
        h  = int'(rand_below(800));
        v  = int'(rand_below(525));
        av = rand_below(4) != 0;
        check_pixel(h, v, av, expect_pixel(h, v, av));
    endtask

    // Window line 151 is the top row of the latched sprite
    task automatic check_final_row();
        int col;
        for (int r = 0; r < 3; r++) begin
            repeat (4) begin
                col = int'(rand_below(reel_width));
                check_pixel(reel_start_h[r] + col, reels_start_v + centering_offset, 1'b1,
                            model_color(latched[r], 0, col / 2));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////
    initial begin
        int spin_frames;
        reset_n       = 1'b0;
        hcount        = '0;
        vcount        = '0;
        vsync         = 1'b0;
        active_video  = 1'b0;
        start_spin    = 1'b0;
        final1_sprite = '0;
        final2_sprite = '0;
        final3_sprite = '0;
        m_state       = int'(idle);
        m_req         = 0;
        for (int r = 0; r < 3; r++) begin
            m_off[r]   = 0;
            m_turns[r] = 0;
            m_end[r]   = 0;
            latched[r] = 0;
        end
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        repeat (2) @(negedge clk);

        // Reset values and blanking
        check_state();
        check_pixel(100, 200, 1'b1, 3'd0);
        check_pixel(350, 200, 1'b1, 3'd0);
        check_pixel(250, 30, 1'b1, 3'd0);
        check_pixel(250, 200, 1'b0, 3'd0);
        check_pixel(650, 480, 1'b0, 3'd0);

        // Still reels at offset 0
        repeat (2) begin
            emit_frame();
            repeat (3) sample_frame_pixels();
        end

        final1_sprite = 3'(rand_below(num_sprites));
        final2_sprite = 3'(rand_below(num_sprites));
        final3_sprite = 3'(rand_below(num_sprites));
        latched[0]    = int'(final1_sprite);
        latched[1]    = int'(final2_sprite);
        latched[2]    = int'(final3_sprite);
        for (int r = 0; r < 3; r++) begin
            m_end[r] = ending_line(r, latched[r]);
        end
        start_spin = 1'b1;
        m_req      = 1;
        @(negedge clk);
        start_spin = 1'b0;

        spin_frames = 0;
        while (m_state != int'(finished) && spin_frames < max_spin_frames) begin
            emit_frame();
            sample_frame_pixels();
            spin_frames++;
            if (spin_frames == 100) begin
                final1_sprite = other_sprite(latched[0]);
                final2_sprite = other_sprite(latched[1]);
                final3_sprite = other_sprite(latched[2]);
            end
        end
        if (m_state != int'(finished)) begin
            errors++;
            $display("Spin did not reach the finished state in %0d frames", spin_frames);
        end

        // Let the earlier reels finish their creep
        repeat (settle_frames) begin
            emit_frame();
            sample_frame_pixels();
        end
        check_final_row();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* slot_reels.f */
src/reel_display_pkg.sv
src/reel_spin_pkg.sv
src/reel_spin_ctrl.sv
src/reel_scan_addr.sv
src/sprite_rom.sv
src/pixel_out.sv
src/slot_reels_top.sv
tests/tb_slot_reels.sv

/* Bender.yml */
package:
  name: slot_reels

sources:
  - src/reel_display_pkg.sv
  - src/reel_spin_pkg.sv
  - src/reel_spin_ctrl.sv
  - src/reel_scan_addr.sv
  - src/sprite_rom.sv
  - src/pixel_out.sv
  - src/slot_reels_top.sv
  - target: test
    files:
      - tests/tb_slot_reels.sv
